// File: include/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W          32
`define SOC_DATA_W          64

// Boot ROM region, 16 words of content repeated over the whole region
`define SOC_ROM_BASE        32'h0000_1000
`define SOC_ROM_LEN         32'h0000_1000
`define SOC_ROM_WORDS       16
`define SOC_ROM_SIGNATURE   32'hB007_C0DE

// Core-local interruptor
`define SOC_CLINT_BASE      32'h0200_0000
`define SOC_CLINT_LEN       32'h0000_C000
`define SOC_MSIP_OFS        32'h0000_0000
`define SOC_MTIMECMP_OFS    32'h0000_4000
`define SOC_MTIME_OFS       32'h0000_BFF8

// Data SRAM, 256 words aliased over the region
`define SOC_SRAM_BASE       32'h8000_0000
`define SOC_SRAM_LEN        32'h0001_0000
`define SOC_SRAM_WORDS      256

// Fabric reset hold after the last reset cause
`define SOC_RST_HOLD_CYCLES 16

`endif

// File: hw/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // ----------------------------------------
  // Bus vectors
  // ----------------------------------------
  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W-1:0]   data_t;
  typedef logic [`SOC_DATA_W/8-1:0] strb_t;

  // Target selected by the address decoder
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_ROM   = 2'd1,
    REGION_SRAM  = 2'd2,
    REGION_CLINT = 2'd3
  } region_e;

  // Fabric reset sequencer
  typedef enum logic {
    RST_HOLD = 1'b0,
    RST_RUN  = 1'b1
  } rst_state_e;

  // Replace only the bytes whose enable is set
  function automatic data_t merge_be(data_t cur, data_t wdata, strb_t be);
    data_t res;
    int    b;
    res = cur;
    for (b = 0; b < $bits(strb_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: hw/soc_reset_fsm.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_reset_fsm (
  input  logic clk_i,
  input  logic rst_i,
  input  logic dbg_reset_req_i,
  output logic fabric_rst_o,
  output logic fabric_ready_o
);
  import soc_pkg::*;

  localparam int CNT_W = $clog2(`SOC_RST_HOLD_CYCLES + 1);

  rst_state_e       state_q;
  logic [CNT_W-1:0] hold_cnt_q;

  // Every reset cause restarts the hold window
  always_ff @(posedge clk_i) begin
    if (rst_i || dbg_reset_req_i) begin
      state_q    <= RST_HOLD;
      hold_cnt_q <= CNT_W'(`SOC_RST_HOLD_CYCLES);
    end else begin
      case (state_q)
        RST_HOLD: begin
          if (hold_cnt_q == '0) begin
            state_q <= RST_RUN;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        RST_RUN: begin
          state_q <= RST_RUN;
        end
        default: begin
          state_q <= RST_HOLD;
        end
      endcase
    end
  end

  assign fabric_rst_o   = (state_q == RST_HOLD);
  assign fabric_ready_o = (state_q == RST_RUN);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_ready_rst_excl: assert property (@(posedge clk_i) disable iff (rst_i !== 1'b0)
    !(fabric_ready_o && fabric_rst_o));

endmodule

// File: hw/soc_addr_decode.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_addr_decode (
  input  logic           clk_i,
  input  logic           fabric_rst_i,
  input  logic           fabric_ready_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t rom_rdata_i,
  input  soc_pkg::data_t sram_rdata_i,
  input  soc_pkg::data_t clint_rdata_i,
  output logic           rom_req_o,
  output logic           sram_req_o,
  output logic           clint_req_o,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o
);
  import soc_pkg::*;

  region_e region_d;
  region_e region_q;
  logic    accept;
  logic    req_err;
  logic    rvalid_q;
  logic    err_q;
  logic    rd_q;

  // Wrapping subtract keeps this a single compare per region
  function automatic logic in_range(addr_t addr, addr_t base, addr_t len);
    addr_t ofs;
    ofs = addr - base;
    return ofs < len;
  endfunction

  always_comb begin
    region_d = REGION_NONE;
    if (in_range(addr_i, `SOC_ROM_BASE, `SOC_ROM_LEN)) begin
      region_d = REGION_ROM;
    end else if (in_range(addr_i, `SOC_SRAM_BASE, `SOC_SRAM_LEN)) begin
      region_d = REGION_SRAM;
    end else if (in_range(addr_i, `SOC_CLINT_BASE, `SOC_CLINT_LEN)) begin
      region_d = REGION_CLINT;
    end
  end

  assign accept  = req_i & fabric_ready_i;
  // Unmapped hole or a store into the boot ROM
  assign req_err = (region_d == REGION_NONE) | ((region_d == REGION_ROM) & we_i);

  assign rom_req_o   = accept & (region_d == REGION_ROM) & ~we_i;
  assign sram_req_o  = accept & (region_d == REGION_SRAM);
  assign clint_req_o = accept & (region_d == REGION_CLINT);

  // ----------------------------------------
  // Response stage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (fabric_rst_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rd_q     <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      rvalid_q <= accept;
      err_q    <= accept & req_err;
      rd_q     <= accept & ~we_i & ~req_err;
      region_q <= region_d;
    end
  end

  // Writes and errors return zero data
  always_comb begin
    rdata_o = '0;
    if (rd_q) begin
      case (region_q)
        REGION_ROM:   rdata_o = rom_rdata_i;
        REGION_SRAM:  rdata_o = sram_rdata_i;
        REGION_CLINT: rdata_o = clint_rdata_i;
        default:      rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  a_strobe_onehot: assert property (@(posedge clk_i) disable iff (fabric_rst_i !== 1'b0)
    $onehot0({rom_req_o, sram_req_o, clint_req_o}));

  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (fabric_rst_i !== 1'b0)
    rvalid_o |-> $past(req_i && fabric_ready_i));

endmodule

// File: hw/soc_bootrom.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_bootrom (
  input  logic           clk_i,
  input  logic           req_i,
  input  soc_pkg::addr_t addr_i,
  output soc_pkg::data_t rdata_o
);
  import soc_pkg::*;

  localparam int OFS_W = $clog2(`SOC_DATA_W / 8);
  localparam int IDX_W = $clog2(`SOC_ROM_WORDS);

  logic [IDX_W-1:0] word_idx;
  data_t            rom_word;

  // Upper address bits alias onto the same 16 words
  assign word_idx = addr_i[OFS_W +: IDX_W];

  // Signature on top, word index below
  assign rom_word = {`SOC_ROM_SIGNATURE, {(32 - IDX_W){1'b0}}, word_idx};

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule

// File: hw/soc_sram.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_sram (
  input  logic           clk_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o
);
  import soc_pkg::*;

  localparam int OFS_W = $clog2(`SOC_DATA_W / 8);
  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

  // Contents survive a debug reset
  data_t            mem_q [`SOC_SRAM_WORDS];
  logic [IDX_W-1:0] word_idx;

  assign word_idx = addr_i[OFS_W +: IDX_W];

  // ----------------------------------------
  // Single port with one write or read per request
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[word_idx] <= merge_be(mem_q[word_idx], wdata_i, be_i);
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  a_addr_known: assert property (@(posedge clk_i)
    req_i |-> !$isunknown(addr_i));

endmodule

// File: hw/soc_clint.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_clint (
  input  logic           clk_i,
  input  logic           fabric_rst_i,
  input  logic           rtc_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  localparam int OFS_W = $clog2(`SOC_DATA_W / 8);

  addr_t      reg_ofs;
  addr_t      word_ofs;
  data_t      msip_q;
  data_t      mtime_q;
  data_t      mtimecmp_q;
  data_t      rd_word;
  logic [2:0] rtc_sync_q;
  logic       rtc_rise;
  logic       wr_msip;
  logic       wr_mtimecmp;
  logic       wr_mtime;

  // Offset inside the block, byte lanes dropped
  assign reg_ofs  = addr_i - `SOC_CLINT_BASE;
  assign word_ofs = {reg_ofs[`SOC_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  assign wr_msip     = req_i & we_i & (word_ofs == `SOC_MSIP_OFS);
  assign wr_mtimecmp = req_i & we_i & (word_ofs == `SOC_MTIMECMP_OFS);
  assign wr_mtime    = req_i & we_i & (word_ofs == `SOC_MTIME_OFS);

  // Two sync flops, third one holds the previous level
  assign rtc_rise = rtc_sync_q[1] & ~rtc_sync_q[2];

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (fabric_rst_i) begin
      rtc_sync_q <= '0;
      msip_q     <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      if (wr_msip) begin
        msip_q <= merge_be(msip_q, wdata_i, be_i);
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= merge_be(mtimecmp_q, wdata_i, be_i);
      end
      // Software write wins over a tick in the same cycle
      if (wr_mtime) begin
        mtime_q <= merge_be(mtime_q, wdata_i, be_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    case (word_ofs)
      `SOC_MSIP_OFS:     rd_word = msip_q;
      `SOC_MTIMECMP_OFS: rd_word = mtimecmp_q;
      `SOC_MTIME_OFS:    rd_word = mtime_q;
      default:           rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rd_word;
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q[0];

  // Compare register comes out of reset above any count
  a_no_irq_after_rst: assert property (@(posedge clk_i)
    fabric_rst_i |=> !timer_irq_o);

endmodule

// File: hw/soc_top.sv
`timescale 1ns/10ps

module soc_top (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           rtc_i,
  input  logic           dbg_reset_req_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  output logic           fabric_ready_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  logic  fabric_rst;
  logic  rom_req;
  logic  sram_req;
  logic  clint_req;
  data_t rom_rdata;
  data_t sram_rdata;
  data_t clint_rdata;

  // ----------------------------------------
  // Reset and decode
  // ----------------------------------------
  soc_reset_fsm u_reset_fsm (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .dbg_reset_req_i (dbg_reset_req_i),
    .fabric_rst_o    (fabric_rst),
    .fabric_ready_o  (fabric_ready_o)
  );

  soc_addr_decode u_addr_decode (
    .clk_i          (clk_i),
    .fabric_rst_i   (fabric_rst),
    .fabric_ready_i (fabric_ready_o),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .rom_rdata_i    (rom_rdata),
    .sram_rdata_i   (sram_rdata),
    .clint_rdata_i  (clint_rdata),
    .rom_req_o      (rom_req),
    .sram_req_o     (sram_req),
    .clint_req_o    (clint_req),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .err_o          (err_o)
  );

  // ----------------------------------------
  // Targets
  // ----------------------------------------
  soc_bootrom u_bootrom (
    .clk_i   (clk_i),
    .req_i   (rom_req),
    .addr_i  (addr_i),
    .rdata_o (rom_rdata)
  );

  // Memory sees no reset at all
  soc_sram u_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .wdata_i (wdata_i),
    .rdata_o (sram_rdata)
  );

  soc_clint u_clint (
    .clk_i        (clk_i),
    .fabric_rst_i (fabric_rst),
    .rtc_i        (rtc_i),
    .req_i        (clint_req),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .rdata_o      (clint_rdata),
    .timer_irq_o  (timer_irq_o),
    .ipi_o        (ipi_o)
  );

endmodule

// File: testbench/tb_soc_top.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module tb_soc_top;
  import soc_pkg::*;

  localparam int CLK_HALF = 4;
  localparam int HOLD = `SOC_RST_HOLD_CYCLES;
  // Cycle budget of each test in test order
  localparam int RUN_CYCLES = 40 + 20 + 40 + 20 + 100 + 50;

  logic  clk_i;
  logic  rst_i;
  logic  rtc_i;
  logic  dbg_reset_req_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  strb_t be_i;
  data_t wdata_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  fabric_ready_o;
  logic  timer_irq_o;
  logic  ipi_o;

  logic [31:0] lfsr_q;
  int          check_cnt;
  int          err_cnt;
  int          test_cnt;

  soc_top u_dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .rtc_i           (rtc_i),
    .dbg_reset_req_i (dbg_reset_req_i),
    .req_i           (req_i),
    .we_i            (we_i),
    .addr_i          (addr_i),
    .be_i            (be_i),
    .wdata_i         (wdata_i),
    .rvalid_o        (rvalid_o),
    .rdata_o         (rdata_o),
    .err_o           (err_o),
    .fabric_ready_o  (fabric_ready_o),
    .timer_irq_o     (timer_irq_o),
    .ipi_o           (ipi_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  initial begin
    #(2 * RUN_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired before all tests completed");
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val[i] = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Reference byte merge through a full-width mask
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t mask;
    int    b;
    mask = '0;
    for (b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic check_val(input string sig, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    assert (act === exp) else begin
      $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
      err_cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input strb_t be,
                            input data_t wdata, output data_t rdata, output logic err);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    next_cycle();
    req_i = 1'b0;
    we_i  = 1'b0;
    check_val("rvalid_o", 1, rvalid_o);
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic bus_write(input addr_t addr, input strb_t be, input data_t wdata,
                           input logic exp_err);
    data_t rdata;
    logic  err;
    bus_access(1'b1, addr, be, wdata, rdata, err);
    check_val("err_o", exp_err, err);
    check_val("rdata_o", 0, rdata);
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output logic err);
    bus_access(1'b0, addr, '0, '0, rdata, err);
  endtask

  task automatic check_read(input addr_t addr, input data_t exp, input logic exp_err);
    data_t rdata;
    logic  err;
    bus_read(addr, rdata, err);
    check_val("err_o", exp_err, err);
    check_val("rdata_o", exp, rdata);
  endtask

  task automatic rtc_tick();
    rtc_i = 1'b1;
    repeat (4) next_cycle();
    rtc_i = 1'b0;
    repeat (4) next_cycle();
  endtask

  // Called one step after the last reset cause edge
  task automatic check_hold_window();
    int c;
    // ROM read held on every hold cycle gets no response
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = `SOC_ROM_BASE;
    for (c = 1; c <= HOLD; c++) begin
      next_cycle();
      check_val("fabric_ready_o", 0, fabric_ready_o);
      check_val("rvalid_o", 0, rvalid_o);
      check_val("timer_irq_o", 0, timer_irq_o);
      check_val("ipi_o", 0, ipi_o);
    end
    next_cycle();
    req_i = 1'b0;
    check_val("fabric_ready_o", 1, fabric_ready_o);
    check_val("rvalid_o", 0, rvalid_o);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      $display("[%0t] test %s: ok", $time, name);
    end else begin
      $display("[%0t] test %s: %0d errors", $time, name, err_cnt - errs_at_start);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset();
    int errs0;
    errs0 = err_cnt;
    rst_i = 1'b1;
    repeat (10) next_cycle();
    rst_i = 1'b0;
    check_hold_window();
    report_test("reset", errs0);
  endtask

  task automatic test_rom();
    int    errs0;
    int    k;
    int    rom_idx [5] = '{0, 5, 15, 17, 40};
    data_t exp;
    errs0 = err_cnt;
    for (k = 0; k < 5; k++) begin
      exp = {`SOC_ROM_SIGNATURE, 32'(rom_idx[k] % `SOC_ROM_WORDS)};
      check_read(`SOC_ROM_BASE + 8 * rom_idx[k], exp, 1'b0);
    end
    bus_write(`SOC_ROM_BASE + 8 * 3, 8'hff, 64'hdead_beef_0bad_f00d, 1'b1);
    check_read(`SOC_ROM_BASE + 8 * 3, {`SOC_ROM_SIGNATURE, 32'd3}, 1'b0);
    report_test("rom", errs0);
  endtask

  task automatic test_sram();
    int          errs0;
    int          i;
    data_t       model [8];
    logic [63:0] r;
    logic [63:0] be;
    errs0 = err_cnt;
    for (i = 0; i < 8; i++) begin
      take_bits(64, r);
      bus_write(`SOC_SRAM_BASE + 8 * ((i * 37 + 11) % 256), 8'hff, r, 1'b0);
      model[i] = r;
      take_bits(64, r);
      take_bits(8, be);
      bus_write(`SOC_SRAM_BASE + 8 * ((i * 37 + 11) % 256), be[7:0], r, 1'b0);
      model[i] = merge_bytes(model[i], r, be[7:0]);
    end
    // Back to back reads return one response per cycle
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = `SOC_SRAM_BASE + 8 * 11;
    for (i = 0; i < 8; i++) begin
      next_cycle();
      if (i < 7) begin
        addr_i = `SOC_SRAM_BASE + 8 * (((i + 1) * 37 + 11) % 256);
      end else begin
        req_i = 1'b0;
      end
      check_val("rvalid_o", 1, rvalid_o);
      check_val("err_o", 0, err_o);
      check_val("rdata_o", model[i], rdata_o);
    end
    next_cycle();
    check_val("rvalid_o", 0, rvalid_o);
    report_test("sram", errs0);
  endtask

  task automatic test_unmapped();
    int    errs0;
    int    k;
    addr_t holes [5] = '{32'h0000_0800, `SOC_ROM_BASE + `SOC_ROM_LEN, 32'h4000_0000,
                         `SOC_CLINT_BASE + `SOC_CLINT_LEN, `SOC_SRAM_BASE + `SOC_SRAM_LEN};
    errs0 = err_cnt;
    for (k = 0; k < 5; k++) begin
      check_read(holes[k], '0, 1'b1);
      bus_write(holes[k], 8'hff, 64'h1234_5678_9abc_def0, 1'b1);
    end
    report_test("unmapped", errs0);
  endtask

  task automatic test_clint();
    int    errs0;
    int    k;
    data_t t;
    data_t t_next;
    logic  err;
    errs0 = err_cnt;
    bus_write(`SOC_CLINT_BASE + `SOC_MSIP_OFS, 8'h01, 64'h1, 1'b0);
    check_val("ipi_o", 1, ipi_o);
    bus_write(`SOC_CLINT_BASE + `SOC_MSIP_OFS, 8'h01, 64'h0, 1'b0);
    check_val("ipi_o", 0, ipi_o);
    bus_read(`SOC_CLINT_BASE + `SOC_MTIME_OFS, t, err);
    for (k = 0; k < 4; k++) begin
      rtc_tick();
      bus_read(`SOC_CLINT_BASE + `SOC_MTIME_OFS, t_next, err);
      check_val("mtime", t + 1, t_next);
      t = t_next;
    end
    // Compare three ticks ahead
    bus_write(`SOC_CLINT_BASE + `SOC_MTIMECMP_OFS, 8'hff, t + 3, 1'b0);
    for (k = 0; k < 3; k++) begin
      check_val("timer_irq_o", 0, timer_irq_o);
      rtc_tick();
    end
    check_val("timer_irq_o", 1, timer_irq_o);
    bus_write(`SOC_CLINT_BASE + `SOC_MTIMECMP_OFS, 8'hff, '1, 1'b0);
    check_val("timer_irq_o", 0, timer_irq_o);
    report_test("clint", errs0);
  endtask

  task automatic test_dbg_reset();
    int          errs0;
    int          i;
    data_t       words [4];
    logic [63:0] r;
    errs0 = err_cnt;
    bus_write(`SOC_CLINT_BASE + `SOC_MSIP_OFS, 8'hff, 64'h1, 1'b0);
    for (i = 0; i < 4; i++) begin
      take_bits(64, r);
      words[i] = r;
      bus_write(`SOC_SRAM_BASE + 8 * (200 + i), 8'hff, r, 1'b0);
    end
    check_val("ipi_o", 1, ipi_o);
    dbg_reset_req_i = 1'b1;
    next_cycle();
    dbg_reset_req_i = 1'b0;
    check_val("fabric_ready_o", 0, fabric_ready_o);
    check_hold_window();
    check_val("ipi_o", 0, ipi_o);
    check_read(`SOC_CLINT_BASE + `SOC_MSIP_OFS, '0, 1'b0);
    check_read(`SOC_CLINT_BASE + `SOC_MTIME_OFS, '0, 1'b0);
    for (i = 0; i < 4; i++) begin
      check_read(`SOC_SRAM_BASE + 8 * (200 + i), words[i], 1'b0);
    end
    report_test("dbg_reset", errs0);
  endtask

  initial begin
    rst_i           = 1'b1;
    rtc_i           = 1'b0;
    dbg_reset_req_i = 1'b0;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    be_i            = '0;
    wdata_i         = '0;
    lfsr_q          = 32'hfd50_6089;
    check_cnt       = 0;
    err_cnt         = 0;
    test_cnt        = 0;
    test_reset();
    test_rom();
    test_sram();
    test_unmapped();
    test_clint();
    test_dbg_reset();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
hw/soc_pkg.sv
hw/soc_reset_fsm.sv
hw/soc_addr_decode.sv
hw/soc_bootrom.sv
hw/soc_sram.sv
hw/soc_clint.sv
hw/soc_top.sv
testbench/tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_fabric

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/soc_pkg.sv
      - hw/soc_reset_fsm.sv
      - hw/soc_addr_decode.sv
      - hw/soc_bootrom.sv
      - hw/soc_sram.sv
      - hw/soc_clint.sv
      - hw/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_soc_top.sv
